// ==== src.f ====
verilog/rv32i_isa_pkg.sv
verilog/core_ctrl_pkg.sv
verilog/register_file.sv
verilog/alu.sv
verilog/immediate_extender.sv
verilog/control_fsm.sv
verilog/datapath.sv
verilog/rv32i_multicycle_core.sv
tests/tb_memory.sv
tests/rv32i_core_tb.sv

// ==== Bender.yml ====
package:
  name: rv32i_multicycle_core

sources:
  - verilog/rv32i_isa_pkg.sv
  - verilog/core_ctrl_pkg.sv
  - verilog/register_file.sv
  - verilog/alu.sv
  - verilog/immediate_extender.sv
  - verilog/control_fsm.sv
  - verilog/datapath.sv
  - verilog/rv32i_multicycle_core.sv
  - target: test
    files:
      - tests/tb_memory.sv
      - tests/rv32i_core_tb.sv

// ==== tests/rv32i_core_tb.sv ====
module rv32i_core_tb;

  import core_ctrl_pkg::*;

  localparam logic [31:0] reset_pc = 32'h0000_0080;
  localparam int reset_cycles = 8;
  localparam int slow_delay   = 5;
  localparam int idle_cycles  = 6;
  localparam int pause_cycles = 12;
  localparam int num_tests    = 5;
  localparam int num_instr    = 103; // retires over all tests
  localparam int timeout_cycles = num_instr * (5 + 2 * slow_delay + 4)
    + num_tests * (reset_cycles + 2) + idle_cycles + pause_cycles;

  // major opcodes
  localparam logic [6:0] opc_op     = 7'h33;
  localparam logic [6:0] opc_op_imm = 7'h13;
  localparam logic [6:0] opc_load   = 7'h03;
  localparam logic [6:0] opc_store  = 7'h23;
  localparam logic [6:0] opc_branch = 7'h63;
  localparam logic [6:0] opc_lui    = 7'h37;
  localparam logic [6:0] opc_jal    = 7'h6f;

  localparam int op_add  = 0;
  localparam int op_sub  = 1;
  localparam int op_and  = 2;
  localparam int op_or   = 3;
  localparam int op_xor  = 4;
  localparam int op_sll  = 5;
  localparam int op_srl  = 6;
  localparam int op_sra  = 7;
  localparam int op_slt  = 8;
  localparam int op_sltu = 9;

  logic        clk = 1'b0;
  logic        rst;
  logic        ena;
  logic [2:0]  max_delay;
  mem_req_t    mem_req;
  logic        req;
  logic        ack;
  logic [31:0] rdata;
  logic [31:0] pc;
  logic        retire;

  integer      seed = 32'h2b05_d0e8;
  int          errors = 0;
  int          retire_count = 0;
  int          cycle_count = 0;
  int          prog_len;
  logic [31:0] exp_addr [0:63];
  logic [31:0] exp_data [0:63];
  int          exp_count;
  logic [31:0] opnd_a;
  logic [31:0] opnd_b;
  logic [11:0] imm_vals [0:8];
  logic        req_q;
  logic        ack_q;
  mem_req_t    mem_req_q;

  always #4 clk = ~clk;

  rv32i_multicycle_core #(
    .reset_pc (reset_pc)
  ) i_rv32i_multicycle_core (
    .clk     (clk),
    .rst     (rst),
    .ena     (ena),
    .mem_req (mem_req),
    .req     (req),
    .ack     (ack),
    .rdata   (rdata),
    .pc      (pc),
    .retire  (retire)
  );

  tb_memory #(
    .depth (1024)
  ) i_tb_memory (
    .clk       (clk),
    .rst       (rst),
    .max_delay (max_delay),
    .mem_req   (mem_req),
    .req       (req),
    .ack       (ack),
    .rdata     (rdata)
  );

  task automatic stop_run(input string why);
    errors++;
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected) begin
      stop_run($sformatf("CHECK FAILED %s: got %h, expected %h", name, actual, expected));
    end
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (retire) begin
      retire_count <= retire_count + 1;
    end
    if (cycle_count >= timeout_cycles) begin
      stop_run($sformatf("timeout: the tests did not finish within %0d cycles",
                         timeout_cycles));
    end
  end

  // four-phase rules seen from the bus
  always @(posedge clk) begin
    req_q     <= req;
    ack_q     <= ack;
    mem_req_q <= mem_req;
    if (!rst && req && !req_q && ack_q) begin
      stop_run("handshake error: req rose while ack was still high");
    end else if (!rst && req && req_q && (mem_req !== mem_req_q)) begin
      stop_run("handshake error: mem_req changed while req was high");
    end
  end

  function automatic logic [2:0] funct3_of(input int op);
    case (op)
      op_and:         return 3'b111;
      op_or:          return 3'b110;
      op_xor:         return 3'b100;
      op_sll:         return 3'b001;
      op_srl, op_sra: return 3'b101;
      op_slt:         return 3'b010;
      op_sltu:        return 3'b011;
      default:        return 3'b000;
    endcase
  endfunction

  function automatic logic [31:0] alu_model(input int op, input logic [31:0] a,
                                            input logic [31:0] b);
    case (op)
      op_sub:  return a - b;
      op_and:  return a & b;
      op_or:   return a | b;
      op_xor:  return a ^ b;
      op_sll:  return a << b[4:0];
      op_srl:  return a >> b[4:0];
      op_sra:  return (a >> b[4:0]) | ~({32{~a[31]}} | (32'hffff_ffff >> b[4:0]));
      op_slt:  return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
      op_sltu: return (a < b) ? 32'd1 : 32'd0;
      default: return a + b;
    endcase
  endfunction

  // I-type order: addi slti sltiu xori ori andi slli srli srai
  function automatic int imm_op(input int k);
    case (k)
      1:       return op_slt;
      2:       return op_sltu;
      3:       return op_xor;
      4:       return op_or;
      5:       return op_and;
      6:       return op_sll;
      7:       return op_srl;
      8:       return op_sra;
      default: return op_add;
    endcase
  endfunction

  function automatic logic [31:0] enc_r(input int op, input logic [4:0] rd,
                                        input logic [4:0] rs1, input logic [4:0] rs2);
    logic [6:0] f7;
    f7 = ((op == op_sub) || (op == op_sra)) ? 7'h20 : 7'h00;
    return {f7, rs2, rs1, funct3_of(op), rd, opc_op};
  endfunction

  function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [4:0] rs2, input logic [4:0] rs1,
                                        input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opc_store};
  endfunction

  function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                        input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opc_branch};
  endfunction

  function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, opc_jal};
  endfunction

  task automatic emit(input logic [31:0] instr);
    i_tb_memory.load_word(reset_pc + 4 * prog_len, instr);
    prog_len++;
  endtask

  task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
    exp_addr[exp_count] = addr;
    exp_data[exp_count] = data;
    exp_count++;
  endtask

  task automatic compare_stores();
    int i;
    check("store count", i_tb_memory.log_count, exp_count);
    for (i = 0; i < exp_count; i++) begin
      check($sformatf("store %0d addr", i), i_tb_memory.log_addr[i], exp_addr[i]);
      check($sformatf("store %0d data", i), i_tb_memory.log_data[i], exp_data[i]);
    end
  endtask

  task automatic enter_reset(input logic [2:0] delay);
    @(posedge clk);
    rst       <= 1'b1;
    ena       <= 1'b0;
    max_delay <= delay;
    @(posedge clk);
    i_tb_memory.clear_all(); // memory is held in reset here
    prog_len  = 0;
    exp_count = 0;
  endtask

  task automatic leave_reset();
    repeat (reset_cycles - 1) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
  endtask

  task automatic run_retires(input int n);
    int target;
    target = retire_count + n;
    ena <= 1'b1;
    while (retire_count < target) begin
      @(posedge clk);
    end
  endtask

  task automatic test_reset_fetch();
    enter_reset(3'd0);
    emit(enc_i(opc_op_imm, 3'b000, 5'd1, 5'd0, 12'd5));
    emit(enc_s(5'd1, 5'd0, 12'h200));
    expect_store(32'h200, 32'd5);
    leave_reset();
    check("pc", pc, reset_pc);
    check("req", req, 1'b0);
    repeat (idle_cycles) begin
      @(posedge clk);
      check("req", req, 1'b0); // no fetch while frozen
    end
    ena <= 1'b1;
    while (!req) begin
      @(posedge clk);
    end
    check("mem_req.addr", mem_req.addr, reset_pc);
    check("mem_req.we", mem_req.we, 1'b0);
    run_retires(2);
    compare_stores();
  endtask

  task automatic test_alu_ops(input logic [2:0] delay, input logic pause);
    int          k;
    int          op;
    logic [11:0] imm;
    enter_reset(delay);
    i_tb_memory.load_word(32'h200, opnd_a);
    i_tb_memory.load_word(32'h204, opnd_b);
    emit(enc_i(opc_load, 3'b010, 5'd1, 5'd0, 12'h200));
    emit(enc_i(opc_load, 3'b010, 5'd2, 5'd0, 12'h204));
    for (k = 0; k < 10; k++) begin
      emit(enc_r(k, 5'd3, 5'd1, 5'd2));
      emit(enc_s(5'd3, 5'd0, 12'h300 + 4 * k));
      expect_store(32'h300 + 4 * k, alu_model(k, opnd_a, opnd_b));
    end
    for (k = 0; k < 9; k++) begin
      op  = imm_op(k);
      imm = imm_vals[k];
      if ((op == op_sll) || (op == op_srl) || (op == op_sra)) begin
        imm = {(op == op_sra) ? 7'h20 : 7'h00, imm_vals[k][4:0]};
      end
      emit(enc_i(opc_op_imm, funct3_of(op), 5'd4, 5'd1, imm));
      emit(enc_s(5'd4, 5'd0, 12'h328 + 4 * k));
      expect_store(32'h328 + 4 * k, alu_model(op, opnd_a, {{20{imm[11]}}, imm}));
    end
    leave_reset();
    if (pause) begin
      run_retires(15);
      ena <= 1'b0;
      repeat (pause_cycles) @(posedge clk);
      run_retires(25);
    end else begin
      run_retires(40);
    end
    compare_stores();
  endtask

  task automatic test_loads_x0();
    logic [31:0] word;
    enter_reset(3'd2);
    word = $random(seed);
    i_tb_memory.load_word(32'h210, word);
    emit(enc_i(opc_load, 3'b010, 5'd5, 5'd0, 12'h210));
    emit(enc_s(5'd5, 5'd0, 12'h400));
    emit(enc_i(opc_op_imm, 3'b000, 5'd0, 5'd0, 12'h123));
    emit(enc_s(5'd0, 5'd0, 12'h404));
    emit(enc_i(opc_load, 3'b010, 5'd0, 5'd0, 12'h210));
    emit(enc_s(5'd0, 5'd0, 12'h408));
    emit(enc_r(op_add, 5'd0, 5'd5, 5'd5));
    emit(enc_s(5'd0, 5'd0, 12'h40c));
    expect_store(32'h400, word);
    expect_store(32'h404, 32'd0);
    expect_store(32'h408, 32'd0);
    expect_store(32'h40c, 32'd0);
    leave_reset();
    run_retires(8);
    compare_stores();
  endtask

  task automatic test_control_flow();
    enter_reset(3'd1);
    emit(enc_i(opc_op_imm, 3'b000, 5'd1, 5'd0, 12'd7));
    emit(enc_i(opc_op_imm, 3'b000, 5'd2, 5'd0, 12'd7));
    emit(enc_b(3'b000, 5'd1, 5'd2, 13'd8));  // beq taken
    emit(enc_s(5'd1, 5'd0, 12'h500));
    emit(enc_s(5'd2, 5'd0, 12'h504));
    emit(enc_b(3'b001, 5'd1, 5'd2, 13'd8));  // bne not taken
    emit(enc_s(5'd1, 5'd0, 12'h508));
    emit(enc_b(3'b001, 5'd1, 5'd0, 13'd8));  // bne taken
    emit(enc_s(5'd1, 5'd0, 12'h50c));
    emit(enc_b(3'b000, 5'd1, 5'd0, 13'd8));  // beq not taken
    emit(enc_s(5'd1, 5'd0, 12'h510));
    emit({20'habcde, 5'd3, opc_lui});
    emit(enc_s(5'd3, 5'd0, 12'h514));
    emit(enc_j(5'd4, 21'd12));                // jal over two stores
    emit(enc_s(5'd1, 5'd0, 12'h518));
    emit(enc_s(5'd1, 5'd0, 12'h51c));
    emit(enc_s(5'd4, 5'd0, 12'h520));
    expect_store(32'h504, 32'd7);
    expect_store(32'h508, 32'd7);
    expect_store(32'h510, 32'd7);
    expect_store(32'h514, 32'habcd_e000);
    expect_store(32'h520, reset_pc + 32'd56);
    leave_reset();
    run_retires(12);
    check("pc after jal", pc, reset_pc + 32'd64);
    run_retires(1);
    compare_stores();
  endtask

  task automatic draw_operands();
    int k;
    opnd_a = $random(seed);
    opnd_b = $random(seed);
    for (k = 0; k < 9; k++) begin
      imm_vals[k] = $random(seed);
    end
  endtask

  initial begin
    rst       = 1'b1;
    ena       = 1'b0;
    max_delay = 3'd0;
    draw_operands();
    test_reset_fetch();
    test_alu_ops(3'd0, 1'b0);
    test_loads_x0();
    test_control_flow();
    test_alu_ops(slow_delay, 1'b1); // same operands, slow memory and a freeze
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== tests/tb_memory.sv ====
module tb_memory #(
  parameter int depth = 1024
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [2:0]              max_delay,
  input  core_ctrl_pkg::mem_req_t mem_req,
  input  logic                    req,
  output logic                    ack,
  output logic [31:0]             rdata
);

  localparam int idx_w = $clog2(depth);

  logic [31:0] mem [0:depth-1];
  logic [31:0] log_addr [0:63]; // committed writes in order
  logic [31:0] log_data [0:63];
  int          log_count = 0;
  integer      seed = 32'h2b05_d0e8;
  int          wait_left = 0;
  logic        busy = 1'b0;     // delay drawn for the open request

  always @(posedge clk) begin
    if (rst) begin
      ack   <= 1'b0;
      rdata <= 32'd0;
      busy  = 1'b0;
    end else if (ack) begin
      if (!req) begin
        ack <= 1'b0; // last phase of the handshake
      end
    end else if (req) begin
      if (!busy) begin
        busy      = 1'b1;
        wait_left = {$random(seed)} % (max_delay + 1);
      end
      if (wait_left == 0) begin
        busy = 1'b0;
        ack <= 1'b1;
        if (mem_req.we) begin
          mem[mem_req.addr[idx_w+1:2]] = mem_req.wdata;
          log_addr[log_count] = mem_req.addr;
          log_data[log_count] = mem_req.wdata;
          log_count++;
        end else begin
          rdata <= mem[mem_req.addr[idx_w+1:2]];
        end
      end else begin
        wait_left--;
      end
    end
  end

  // background follows the byte address so stray reads stand out
  task automatic clear_all();
    int i;
    for (i = 0; i < depth; i++) begin
      mem[i] = 32'h5a00_0000 ^ (i << 2);
    end
    log_count = 0;
  endtask

  task automatic load_word(input logic [31:0] addr, input logic [31:0] data);
    mem[addr[idx_w+1:2]] = data;
  endtask

endmodule

// ==== verilog/rv32i_multicycle_core.sv ====
module rv32i_multicycle_core #(
  parameter logic [31:0] reset_pc = 32'h0000_0000
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    ena,
  output core_ctrl_pkg::mem_req_t mem_req,
  output logic                    req,
  input  logic                    ack,
  input  logic [31:0]             rdata,
  output logic [31:0]             pc,
  output logic                    retire
);

  import core_ctrl_pkg::*;

  ctrl_t       ctrl;
  dp_status_t  status;
  logic        mem_we;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;

  control_fsm i_control_fsm (
    .clk    (clk),
    .rst    (rst),
    .ena    (ena),
    .status (status),
    .ack    (ack),
    .req    (req),
    .mem_we (mem_we),
    .ctrl   (ctrl),
    .retire (retire)
  );

  datapath #(
    .reset_pc (reset_pc)
  ) i_datapath (
    .clk       (clk),
    .rst       (rst),
    .ctrl      (ctrl),
    .rdata     (rdata),
    .status    (status),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .pc        (pc)
  );

  assign mem_req = '{addr: mem_addr, wdata: mem_wdata, we: mem_we};

endmodule

// ==== verilog/datapath.sv ====
module datapath #(
  parameter logic [31:0] reset_pc = 32'h0000_0000
) (
  input  logic                      clk,
  input  logic                      rst,
  input  core_ctrl_pkg::ctrl_t      ctrl,
  input  logic [31:0]               rdata,
  output core_ctrl_pkg::dp_status_t status,
  output logic [31:0]               mem_addr,
  output logic [31:0]               mem_wdata,
  output logic [31:0]               pc
);

  import core_ctrl_pkg::*;
  import rv32i_isa_pkg::*;

  logic [31:0] old_pc;   // address of the instruction in flight
  logic [31:0] ir;
  logic [31:0] mdr;
  logic [31:0] reg_a;
  logic [31:0] reg_b;
  logic [31:0] alu_out;
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic [31:0] imm;
  logic [31:0] src_a;
  logic [31:0] src_b;
  logic [31:0] alu_result;
  logic        alu_equal;
  logic [31:0] wb_data;
  logic [31:0] pc_plus4;
  logic [31:0] next_pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= reset_pc;
    end else if (ctrl.pc_we) begin
      pc <= next_pc;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.ir_we) begin
      ir     <= rdata;
      old_pc <= pc;
    end
    if (ctrl.mdr_we) begin
      mdr <= rdata;
    end
    if (ctrl.ab_we) begin
      reg_a <= rs1_data;
      reg_b <= rs2_data;
    end
    if (ctrl.alu_out_we) begin
      alu_out <= alu_result;
    end
  end

  register_file i_register_file (
    .clk      (clk),
    .wr_ena   (ctrl.rf_we),
    .wr_addr  (ir[RD_LSB +: REG_W]),
    .wr_data  (wb_data),
    .rd_addr0 (ir[RS1_LSB +: REG_W]),
    .rd_addr1 (ir[RS2_LSB +: REG_W]),
    .rd_data0 (rs1_data),
    .rd_data1 (rs2_data)
  );

  immediate_extender i_immediate_extender (
    .instr (ir),
    .kind  (ctrl.imm_kind),
    .imm   (imm)
  );

  alu i_alu (
    .a      (src_a),
    .b      (src_b),
    .op     (ctrl.alu_op),
    .result (alu_result),
    .equal  (alu_equal)
  );

  assign src_a = (ctrl.src_a_sel == SRC_A_OLD_PC) ? old_pc : reg_a;

  always_comb begin
    case (ctrl.src_b_sel)
      SRC_B_IMM:  src_b = imm;
      SRC_B_FOUR: src_b = 32'd4;
      default:    src_b = reg_b;
    endcase
  end

  assign pc_plus4 = old_pc + 32'd4;

  always_comb begin
    case (ctrl.wb_sel)
      WB_SEL_MEM: wb_data = mdr;
      WB_SEL_PC:  wb_data = pc_plus4;
      WB_SEL_IMM: wb_data = imm;
      default:    wb_data = alu_out;
    endcase
  end

  // target was computed from old pc and immediate during decode
  assign next_pc   = ctrl.pc_from_alu ? alu_out : pc_plus4;
  assign mem_addr  = (ctrl.addr_sel == ADDR_ALU) ? alu_out : pc;
  assign mem_wdata = reg_b;

  assign status = '{instr: ir, equal: alu_equal};

endmodule

// ==== verilog/control_fsm.sv ====
module control_fsm (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      ena,
  input  core_ctrl_pkg::dp_status_t status,
  input  logic                      ack,
  output logic                      req,
  output logic                      mem_we,
  output core_ctrl_pkg::ctrl_t      ctrl,
  output logic                      retire
);

  import core_ctrl_pkg::*;
  import rv32i_isa_pkg::*;

  state_t     state;
  state_t     next_state;
  opcode_t    opcode;
  logic [2:0] funct3;
  logic       alt;
  alu_op_t    funct_op;
  logic       taken;
  logic       ack_seen;
  logic       wr_done;  // write committed while the core was frozen
  logic       step_done;
  logic       hs_next;

  assign opcode = opcode_t'(status.instr[OPCODE_LSB +: OPCODE_W]);
  assign funct3 = status.instr[FUNCT3_LSB +: FUNCT3_W];
  assign alt    = status.instr[FUNCT7_LSB + FUNCT7_ALT];

  assign ack_seen  = req && ack;
  assign step_done = ack_seen || wr_done;
  assign hs_next   = (next_state == FETCH) || (next_state == MEM_RD) || (next_state == MEM_WR);
  assign mem_we    = (state == MEM_WR);

  // funct fields to ALU operation; sub only exists for register operands
  always_comb begin
    case (funct3)
      F3_ADD_SUB: funct_op = (alt && (opcode == OPC_OP)) ? ALU_SUB : ALU_ADD;
      F3_SLL:     funct_op = ALU_SLL;
      F3_SLT:     funct_op = ALU_SLT;
      F3_SLTU:    funct_op = ALU_SLTU;
      F3_XOR:     funct_op = ALU_XOR;
      F3_SRL_SRA: funct_op = alt ? ALU_SRA : ALU_SRL;
      F3_OR:      funct_op = ALU_OR;
      F3_AND:     funct_op = ALU_AND;
      default:    funct_op = ALU_ADD;
    endcase
  end

  always_comb begin
    case (funct3)
      F3_BEQ:  taken = status.equal;
      F3_BNE:  taken = !status.equal;
      default: taken = 1'b0; // other compares are not supported
    endcase
  end

  always_comb begin
    next_state    = state;
    ctrl          = '0;
    retire        = 1'b0;
    // address select follows the state so the request holds while frozen
    ctrl.addr_sel = ((state == MEM_RD) || (state == MEM_WR)) ? ADDR_ALU : ADDR_PC;
    if (ena) begin
      case (state)
        IDLE: begin
          next_state = FETCH;
        end
        FETCH: begin
          if (ack_seen) begin
            ctrl.ir_we = 1'b1;
            next_state = DECODE;
          end
        end
        DECODE: begin
          ctrl.ab_we      = 1'b1;
          ctrl.alu_out_we = 1'b1; // branch or jump target while the ALU is free
          ctrl.src_a_sel  = SRC_A_OLD_PC;
          ctrl.src_b_sel  = SRC_B_IMM;
          ctrl.alu_op     = ALU_ADD;
          ctrl.imm_kind   = (opcode == OPC_JAL) ? IMM_J : IMM_B;
          case (opcode)
            OPC_OP:               next_state = EXEC_R;
            OPC_OP_IMM:           next_state = EXEC_I;
            OPC_LOAD, OPC_STORE:  next_state = ADDR_CALC;
            OPC_BRANCH:           next_state = BRANCH;
            OPC_JAL:              next_state = JUMP;
            OPC_LUI:              next_state = LUI_WB;
            default: begin // unknown opcode, just step the pc
              ctrl.pc_we = 1'b1;
              retire     = 1'b1;
              next_state = FETCH;
            end
          endcase
        end
        EXEC_R: begin
          ctrl.alu_op     = funct_op;
          ctrl.alu_out_we = 1'b1;
          next_state      = WB_ALU;
        end
        EXEC_I: begin
          ctrl.src_b_sel  = SRC_B_IMM;
          ctrl.imm_kind   = IMM_I;
          ctrl.alu_op     = funct_op;
          ctrl.alu_out_we = 1'b1;
          next_state      = WB_ALU;
        end
        ADDR_CALC: begin
          ctrl.src_b_sel  = SRC_B_IMM;
          ctrl.imm_kind   = (opcode == OPC_STORE) ? IMM_S : IMM_I;
          ctrl.alu_op     = ALU_ADD;
          ctrl.alu_out_we = 1'b1;
          next_state      = (opcode == OPC_STORE) ? MEM_WR : MEM_RD;
        end
        MEM_RD: begin
          if (ack_seen) begin
            ctrl.mdr_we = 1'b1;
            next_state  = WB_MEM;
          end
        end
        MEM_WR: begin
          if (step_done) begin
            ctrl.pc_we = 1'b1;
            retire     = 1'b1;
            next_state = FETCH;
          end
        end
        WB_ALU, WB_MEM: begin
          ctrl.rf_we  = 1'b1;
          ctrl.wb_sel = (state == WB_MEM) ? WB_SEL_MEM : WB_SEL_ALU;
          ctrl.pc_we  = 1'b1;
          retire      = 1'b1;
          next_state  = FETCH;
        end
        BRANCH: begin
          ctrl.alu_op      = ALU_SUB; // only the equal flag matters here
          ctrl.pc_we       = 1'b1;
          ctrl.pc_from_alu = taken;
          retire           = 1'b1;
          next_state       = FETCH;
        end
        JUMP: begin
          ctrl.rf_we       = 1'b1;
          ctrl.wb_sel      = WB_SEL_PC; // link value
          ctrl.pc_we       = 1'b1;
          ctrl.pc_from_alu = 1'b1;
          retire           = 1'b1;
          next_state       = FETCH;
        end
        LUI_WB: begin
          ctrl.rf_we    = 1'b1;
          ctrl.wb_sel   = WB_SEL_IMM;
          ctrl.imm_kind = IMM_U;
          ctrl.pc_we    = 1'b1;
          retire        = 1'b1;
          next_state    = FETCH;
        end
        default: begin
          next_state = IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= IDLE;
      req     <= 1'b0;
      wr_done <= 1'b0;
    end else begin
      state <= next_state;
      // req rises with the state change, once the last ack is gone
      if (ack_seen) begin
        req <= 1'b0;
      end else if (ena && !req && !ack && !wr_done && hs_next) begin
        req <= 1'b1;
      end
      if ((state == MEM_WR) && ack_seen && !ena) begin
        wr_done <= 1'b1;
      end else if (ena) begin
        wr_done <= 1'b0;
      end
    end
  end

endmodule

// ==== verilog/immediate_extender.sv ====
module immediate_extender (
  input  logic [31:0]              instr,
  input  core_ctrl_pkg::imm_kind_t kind,
  output logic [31:0]              imm
);

  import core_ctrl_pkg::*;

  always_comb begin
    case (kind)
      IMM_I: begin
        imm = {{20{instr[31]}}, instr[31:20]};
      end
      IMM_S: begin
        imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      end
      IMM_B: begin // offsets are in halfwords
        imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      IMM_U: begin
        imm = {instr[31:12], 12'd0};
      end
      IMM_J: begin
        imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      default: begin
        imm = 32'd0;
      end
    endcase
  end

endmodule

// ==== verilog/alu.sv ====
module alu (
  input  logic [31:0]            a,
  input  logic [31:0]            b,
  input  core_ctrl_pkg::alu_op_t op,
  output logic [31:0]            result,
  output logic                   equal
);

  import core_ctrl_pkg::*;

  logic [4:0] shamt;

  assign shamt = b[4:0]; // only the low 5 bits shift

  always_comb begin
    case (op)
      ALU_ADD: begin
        result = a + b;
      end
      ALU_SUB: begin
        result = a - b;
      end
      ALU_AND: begin
        result = a & b;
      end
      ALU_OR: begin
        result = a | b;
      end
      ALU_XOR: begin
        result = a ^ b;
      end
      ALU_SLL: begin
        result = a << shamt;
      end
      ALU_SRL: begin
        result = a >> shamt;
      end
      ALU_SRA: begin
        result = $signed(a) >>> shamt;
      end
      ALU_SLT: begin
        result = {31'd0, $signed(a) < $signed(b)};
      end
      ALU_SLTU: begin
        result = {31'd0, a < b};
      end
      default: begin
        result = a + b;
      end
    endcase
  end

  assign equal = (a == b); // branch compare of the operands

endmodule

// ==== verilog/register_file.sv ====
module register_file (
  input  logic        clk,
  input  logic        wr_ena,
  input  logic [4:0]  wr_addr,
  input  logic [31:0] wr_data,
  input  logic [4:0]  rd_addr0,
  input  logic [4:0]  rd_addr1,
  output logic [31:0] rd_data0,
  output logic [31:0] rd_data1
);

  logic [31:0] regs [1:31]; // x0 has no storage

  always_ff @(posedge clk) begin
    if (wr_ena && (wr_addr != 5'd0)) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // asynchronous read, x0 always zero
  assign rd_data0 = (rd_addr0 == 5'd0) ? 32'd0 : regs[rd_addr0];
  assign rd_data1 = (rd_addr1 == 5'd0) ? 32'd0 : regs[rd_addr1];

endmodule

// ==== verilog/core_ctrl_pkg.sv ====
package core_ctrl_pkg;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU
  } alu_op_t;

  typedef enum logic [3:0] {
    IDLE,
    FETCH,
    DECODE,
    EXEC_R,
    EXEC_I,
    ADDR_CALC,
    MEM_RD,
    MEM_WR,
    WB_ALU,
    WB_MEM,
    BRANCH,
    JUMP,
    LUI_WB
  } state_t;

  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_kind_t;

  typedef enum logic {SRC_A_REG, SRC_A_OLD_PC} src_a_sel_t;
  typedef enum logic [1:0] {SRC_B_REG, SRC_B_IMM, SRC_B_FOUR} src_b_sel_t;
  typedef enum logic [1:0] {WB_SEL_ALU, WB_SEL_MEM, WB_SEL_PC, WB_SEL_IMM} wb_sel_t;
  typedef enum logic {ADDR_PC, ADDR_ALU} addr_sel_t;

  // controller to datapath, 20 bits
  typedef struct packed {
    logic       pc_we;
    logic       ir_we;
    logic       mdr_we;
    logic       ab_we;
    logic       alu_out_we;
    logic       rf_we;
    logic       pc_from_alu; // take the target held in the ALU result register
    alu_op_t    alu_op;
    imm_kind_t  imm_kind;
    src_a_sel_t src_a_sel;
    src_b_sel_t src_b_sel;
    wb_sel_t    wb_sel;
    addr_sel_t  addr_sel;
  } ctrl_t;

  typedef struct packed {
    logic [31:0] instr;
    logic        equal;
  } dp_status_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        we;
  } mem_req_t;

endpackage

// ==== verilog/rv32i_isa_pkg.sv ====
package rv32i_isa_pkg;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_LUI    = 7'b0110111,
    OPC_JAL    = 7'b1101111
  } opcode_t;

  // funct3 of the ALU operations, shared by OP and OP_IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct3 of the branches
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;

  // bit inside funct7 that picks sub and sra
  localparam int unsigned FUNCT7_ALT = 5;

  // lsb of each instruction field
  localparam int unsigned OPCODE_LSB = 0;
  localparam int unsigned RD_LSB     = 7;
  localparam int unsigned FUNCT3_LSB = 12;
  localparam int unsigned RS1_LSB    = 15;
  localparam int unsigned RS2_LSB    = 20;
  localparam int unsigned FUNCT7_LSB = 25;

  // widths of the fields
  localparam int unsigned OPCODE_W = 7;
  localparam int unsigned REG_W    = 5;
  localparam int unsigned FUNCT3_W = 3;

endpackage
